//--- Makefile
# Verilator build and run of the core testbench

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module cpuCoreTb \
		-f tb.f -o cpuCoreSim

run: compile
	./obj_dir/cpuCoreSim

clean:
	rm -rf obj_dir

.PHONY: compile run clean

//--- hw/cpuCore.sv
/* Five-stage core without branches or hazard logic. Load the program with
   imemLoad while reset is held */
`default_nettype none

module cpuCore (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::imemLoadT imemLoad,
    output cpuPkg::wbT       wbReport
);

    import cpuPkg::*;

    ifIdT  ifId;
    idExT  idEx;
    exMemT exMem;
    wbT    writeback;

    fetchStage i_fetch (
        .clk      (clk),
        .reset    (reset),
        .imemLoad (imemLoad),
        .ifId     (ifId)
    );

    decodeStage i_decode (
        .clk       (clk),
        .reset     (reset),
        .ifId      (ifId),
        .writeback (writeback),
        .idEx      (idEx)
    );

    executeStage i_execute (
        .clk   (clk),
        .reset (reset),
        .idEx  (idEx),
        .exMem (exMem)
    );

    memoryStage i_memory (
        .clk       (clk),
        .reset     (reset),
        .exMem     (exMem),
        .writeback (writeback)
    );

    // Every register file write is also reported
    assign wbReport = writeback;

endmodule

`default_nettype wire

//--- hw/cpuMacros.svh
/* Sizes shared by the core. Memory depths must be powers of two, and the
   instruction depth must match the 8-bit word address of the load port */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and address width
`define CPU_XLEN 32

// Architectural registers, register 0 reads as zero
`define CPU_REG_COUNT 32

// Instruction memory depth in 32-bit words
`define CPU_IMEM_WORDS 256

// Data memory depth in 32-bit words
`define CPU_DMEM_WORDS 128

`endif

//--- hw/cpuPkg.sv
/* Opcode, ALU and pipeline register types. Field widths follow cpuMacros.svh */
`include "cpuMacros.svh"
`default_nettype none

package cpuPkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        rType = 6'b000000,
        addi  = 6'b001000,
        slti  = 6'b001010,
        andi  = 6'b001100,
        ori   = 6'b001101,
        lw    = 6'b100011,
        sw    = 6'b101011
    } opcodeT;

    // Class handed from the decoder to ALU control
    typedef enum logic [2:0] {
        addClass   = 3'b000,
        functClass = 3'b010,
        sltClass   = 3'b011,
        orClass    = 3'b100,
        andClass   = 3'b101
    } aluOpT;

    typedef enum logic [3:0] {
        andOp = 4'b0000,
        orOp  = 4'b0001,
        addOp = 4'b0010,
        subOp = 4'b0110,
        sltOp = 4'b0111
    } aluFuncT;

    // #################### Pipeline registers

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrc;
        logic  regDst;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] instruction;
    } ifIdT;

    typedef struct packed {
        logic                               valid;
        ctrlT                               ctrl;
        logic [`CPU_XLEN-1:0]               readData1;
        logic [`CPU_XLEN-1:0]               readData2;
        logic [`CPU_XLEN-1:0]               immediate;
        logic [$clog2(`CPU_REG_COUNT)-1:0]  rt;
        logic [$clog2(`CPU_REG_COUNT)-1:0]  rd;
    } idExT;

    typedef struct packed {
        logic                               valid;
        ctrlT                               ctrl;
        logic [`CPU_XLEN-1:0]               aluResult;
        logic [`CPU_XLEN-1:0]               storeData;
        logic [$clog2(`CPU_REG_COUNT)-1:0]  destReg;
    } exMemT;

    // Register file write, also the externally visible report
    typedef struct packed {
        logic                               valid;
        logic [$clog2(`CPU_REG_COUNT)-1:0]  destReg;
        logic [`CPU_XLEN-1:0]               data;
    } wbT;

    typedef struct packed {
        logic                               enable;
        logic [$clog2(`CPU_IMEM_WORDS)-1:0] wordAddress;
        logic [`CPU_XLEN-1:0]               word;
    } imemLoadT;

endpackage

`default_nettype wire

//--- hw/decodeStage.sv
/* No forwarding or hazard checks. A register read in the cycle of its write
   returns the old value, so producers need three nops behind them */
`include "cpuMacros.svh"
`default_nettype none

module decodeStage (
    input  logic         clk,
    input  logic         reset,
    input  cpuPkg::ifIdT ifId,
    input  cpuPkg::wbT   writeback,
    output cpuPkg::idExT idEx
);

    import cpuPkg::*;

    localparam int regBits = $clog2(`CPU_REG_COUNT);

    logic [`CPU_XLEN-1:0] registers [`CPU_REG_COUNT];
    opcodeT               opcode;
    ctrlT                 ctrl;
    logic [regBits-1:0]   rs;
    logic [regBits-1:0]   rt;
    logic [regBits-1:0]   rd;
    logic [`CPU_XLEN-1:0] immediate;

    assign opcode = opcodeT'(ifId.instruction[31:26]);
    assign rs     = ifId.instruction[25:21];
    assign rt     = ifId.instruction[20:16];
    assign rd     = ifId.instruction[15:11];

    // andi and ori are sign extended too
    assign immediate = {{(`CPU_XLEN-16){ifId.instruction[15]}}, ifId.instruction[15:0]};

    // #################### Main control
    always_comb begin
        ctrl = '0;
        case (opcode)
            rType: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                ctrl.aluOp    = functClass;
            end
            addi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = addClass;
            end
            andi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = andClass;
            end
            ori: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = orClass;
            end
            slti: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = sltClass;
            end
            lw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = addClass;
            end
            sw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = addClass;
            end
            // Unknown opcodes fall through as a nop
            default: ctrl = '0;
        endcase
    end

    // #################### Register file
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (writeback.valid) begin
            registers[writeback.destReg] <= writeback.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.valid <= 1'b0;
            idEx.ctrl  <= '0;
        end else begin
            idEx.valid <= ifId.valid;
            idEx.ctrl  <= ifId.valid ? ctrl : '0;
        end
        idEx.readData1 <= registers[rs];
        idEx.readData2 <= registers[rt];
        idEx.immediate <= immediate;
        idEx.rt        <= rt;
        idEx.rd        <= rd;
    end

endmodule

`default_nettype wire

//--- hw/executeStage.sv
/* slt and slti compare unsigned. The funct field is taken from the low bits
   of the sign-extended immediate */
`include "cpuMacros.svh"
`default_nettype none

module executeStage (
    input  logic          clk,
    input  logic          reset,
    input  cpuPkg::idExT  idEx,
    output cpuPkg::exMemT exMem
);

    import cpuPkg::*;

    aluFuncT              aluFunc;
    logic [`CPU_XLEN-1:0] operandA;
    logic [`CPU_XLEN-1:0] operandB;
    logic [`CPU_XLEN-1:0] aluResult;
    logic [4:0]           destReg;

    // ALU control
    always_comb begin
        case (idEx.ctrl.aluOp)
            functClass: begin
                case (idEx.immediate[5:0])
                    6'd32:   aluFunc = addOp;
                    6'd34:   aluFunc = subOp;
                    6'd36:   aluFunc = andOp;
                    6'd37:   aluFunc = orOp;
                    6'd42:   aluFunc = sltOp;
                    default: aluFunc = addOp;
                endcase
            end
            sltClass: aluFunc = sltOp;
            orClass:  aluFunc = orOp;
            andClass: aluFunc = andOp;
            default:  aluFunc = addOp;
        endcase
    end

    assign operandA = idEx.readData1;
    assign operandB = idEx.ctrl.aluSrc ? idEx.immediate : idEx.readData2;

    always_comb begin
        case (aluFunc)
            andOp:   aluResult = operandA & operandB;
            orOp:    aluResult = operandA | operandB;
            subOp:   aluResult = operandA - operandB;
            sltOp:   aluResult = {{(`CPU_XLEN-1){1'b0}}, operandA < operandB};
            default: aluResult = operandA + operandB;
        endcase
    end

    // R-type writes rd, immediate forms write rt
    assign destReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem.valid <= 1'b0;
            exMem.ctrl  <= '0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.ctrl  <= idEx.ctrl;
        end
        exMem.aluResult <= aluResult;
        exMem.storeData <= idEx.readData2;
        exMem.destReg   <= destReg;
    end

endmodule

`default_nettype wire

//--- hw/fetchStage.sv
/* PC steps one word per cycle with no branches. The load port only writes
   while reset is high */
`include "cpuMacros.svh"
`default_nettype none

module fetchStage (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::imemLoadT imemLoad,
    output cpuPkg::ifIdT     ifId
);

    localparam int pcBits = $clog2(`CPU_IMEM_WORDS);

    logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_WORDS];
    logic [pcBits-1:0]    pc;

    // Program load while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset && imemLoad.enable) begin
            imem[imemLoad.wordAddress] <= imemLoad.word;
        end
    end

    // Word counter, wraps at the end of instruction memory
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ifId.valid <= 1'b0;
        end else begin
            ifId.valid <= 1'b1;
        end
        ifId.instruction <= imem[pc];
    end

endmodule

`default_nettype wire

//--- hw/memoryStage.sv
/* Data memory is word addressed by aluResult[8:2]; the low two bits and the
   upper bits are ignored. Writes to register 0 are dropped here */
`include "cpuMacros.svh"
`default_nettype none

module memoryStage (
    input  logic          clk,
    input  logic          reset,
    input  cpuPkg::exMemT exMem,
    output cpuPkg::wbT    writeback
);

    localparam int dmemIdxBits = $clog2(`CPU_DMEM_WORDS);

    logic [`CPU_XLEN-1:0]   dmem [`CPU_DMEM_WORDS];
    logic [dmemIdxBits-1:0] dmemIndex;
    logic [`CPU_XLEN-1:0]   loadData;

    // Memory/writeback register
    logic                 wbValid;
    logic                 wbRegWrite;
    logic                 wbMemToReg;
    logic [4:0]           wbDestReg;
    logic [`CPU_XLEN-1:0] wbAluResult;
    logic [`CPU_XLEN-1:0] wbLoadData;

    assign dmemIndex = exMem.aluResult[dmemIdxBits+1:2];
    assign loadData  = exMem.ctrl.memRead ? dmem[dmemIndex] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (exMem.valid && exMem.ctrl.memWrite) begin
            dmem[dmemIndex] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbValid    <= exMem.valid;
            wbRegWrite <= exMem.ctrl.regWrite;
            wbMemToReg <= exMem.ctrl.memToReg;
        end
        wbDestReg   <= exMem.destReg;
        wbAluResult <= exMem.aluResult;
        wbLoadData  <= loadData;
    end

    // ####################
    assign writeback.valid   = wbValid && wbRegWrite && (wbDestReg != '0);
    assign writeback.destReg = wbDestReg;
    assign writeback.data    = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/cpuPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/cpuCore.sv
tb/cpuCoreTb.sv

//--- tb/cpuCoreTb.sv
/* Each program holds at most 63 instructions, each followed by three nops, and
   is loaded through the load port while reset is held */
`include "cpuMacros.svh"
`default_nettype none

module cpuCoreTb;

    timeunit 1ns;
    timeprecision 1ps;

    import cpuPkg::*;

    // Architectural encodings
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] fnAdd   = 6'd32;
    localparam logic [5:0] fnSub   = 6'd34;
    localparam logic [5:0] fnAnd   = 6'd36;
    localparam logic [5:0] fnOr    = 6'd37;
    localparam logic [5:0] fnSlt   = 6'd42;

    logic     clk;
    logic     reset;
    imemLoadT imemLoad;
    wbT       wbReport;

    logic [`CPU_XLEN-1:0] modelRegs [`CPU_REG_COUNT];
    logic [`CPU_XLEN-1:0] modelMem [`CPU_DMEM_WORDS];
    logic [31:0]          progWords [$];
    wbT                   expected [$];
    wbT                   head;
    logic [31:0]          rngState;
    int                   cycleCount = 0;
    int                   cycleLimit = 50;

    cpuCore i_dut (
        .clk      (clk),
        .reset    (reset),
        .imemLoad (imemLoad),
        .wbReport (wbReport)
    );

    always #4 clk = ~clk;

    // #################### Helpers

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] rInstr(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {opRType, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Registers limited to r0..r7 so results feed each other often
    function automatic logic [31:0] randomInstr();
        logic [31:0] sel;
        logic [31:0] immWord;
        logic [15:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        int          kind;
        sel     = nextRandom();
        immWord = nextRandom();
        imm     = immWord[31:16];
        rd      = {2'b00, sel[2:0]};
        rs      = {2'b00, sel[5:3]};
        rt      = {2'b00, sel[8:6]};
        kind    = nextRandom() % 11;
        case (kind)
            0:       return rInstr(fnAdd, rd, rs, rt);
            1:       return rInstr(fnSub, rd, rs, rt);
            2:       return rInstr(fnAnd, rd, rs, rt);
            3:       return rInstr(fnOr, rd, rs, rt);
            4:       return rInstr(fnSlt, rd, rs, rt);
            5:       return iInstr(opAddi, rt, rs, imm);
            6:       return iInstr(opAndi, rt, rs, imm);
            7:       return iInstr(opOri, rt, rs, imm);
            8:       return iInstr(opSlti, rt, rs, imm);
            9:       return iInstr(opLw, rt, 5'd0, {7'd0, sel[20:14], 2'b00});
            default: return iInstr(opSw, rt, 5'd0, {7'd0, sel[20:14], 2'b00});
        endcase
    endfunction

    // Reference model for one instruction in program order
    function automatic wbT executeModel(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        writes;
        wbT          report;
        a      = modelRegs[instr[25:21]];
        b      = modelRegs[instr[20:16]];
        imm    = {{16{instr[15]}}, instr[15:0]};
        addr   = a + imm;
        result = '0;
        dest   = instr[20:16];
        writes = 1'b1;
        case (instr[31:26])
            opRType: begin
                dest = instr[15:11];
                case (instr[5:0])
                    fnSub:   result = a - b;
                    fnAnd:   result = a & b;
                    fnOr:    result = a | b;
                    fnSlt:   result = {31'd0, a < b};
                    default: result = a + b;
                endcase
            end
            opAddi: result = a + imm;
            opAndi: result = a & imm;
            opOri:  result = a | imm;
            opSlti: result = {31'd0, a < imm};
            opLw:   result = modelMem[addr[8:2]];
            opSw: begin
                modelMem[addr[8:2]] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        report.valid   = writes && (dest != 5'd0);
        report.destReg = dest;
        report.data    = result;
        if (report.valid) begin
            modelRegs[dest] = result;
        end
        return report;
    endfunction

    task automatic compareValue(input string what, input logic [31:0] actual,
                                input logic [31:0] expectedValue);
        if (actual !== expectedValue) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, actual,
                     expectedValue);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // Load with reset held, then run until every expected report is seen
    task automatic runProgram();
        int waited;
        wbT report;
        cycleLimit += `CPU_IMEM_WORDS + 20 + 4 * progWords.size();
        for (int r = 0; r < `CPU_REG_COUNT; r++) begin
            modelRegs[r] = '0;
        end
        for (int m = 0; m < `CPU_DMEM_WORDS; m++) begin
            modelMem[m] = '0;
        end
        foreach (progWords[i]) begin
            report = executeModel(progWords[i]);
            if (report.valid) begin
                expected.push_back(report);
            end
        end
        @(negedge clk);
        reset = 1'b1;
        for (int addr = 0; addr < `CPU_IMEM_WORDS; addr++) begin
            imemLoad.enable      = 1'b1;
            imemLoad.wordAddress = addr[7:0];
            imemLoad.word        = (addr % 4 == 0 && addr / 4 < progWords.size()) ?
                                   progWords[addr / 4] : '0;
            @(negedge clk);
        end
        imemLoad = '0;
        repeat (10) @(negedge clk);
        reset  = 1'b0;
        waited = 0;
        // Last instruction reports about 4N+1 cycles after release
        while (expected.size() != 0 || waited < 4 * progWords.size() + 6) begin
            @(negedge clk);
            waited++;
        end
        progWords.delete();
    endtask

    // #################### Checker and timeout

    always @(posedge clk) begin
        if (reset) begin
            if (wbReport.valid === 1'b1) begin
                $display("A writeback was reported at %0d ns while reset was held", $time);
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end else if (wbReport.valid === 1'b1) begin
            if (expected.size() == 0) begin
                $display("An unexpected writeback to register %0d appeared at %0d ns",
                         wbReport.destReg, $time);
                $display("ERRORS FOUND");
                $fatal(1);
            end else begin
                head = expected.pop_front();
                compareValue("destReg", 32'(wbReport.destReg), 32'(head.destReg));
                compareValue("data", wbReport.data, head.data);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, writebacks still missing", cycleCount);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    // #################### Stimulus

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        imemLoad = '0;
        rngState = 32'd58;

        // Directed arithmetic, immediate, memory and unknown opcode tests
        progWords.push_back(iInstr(opAddi, 5'd1, 5'd0, 16'd5));
        progWords.push_back(iInstr(opAddi, 5'd2, 5'd0, 16'hfffd));
        progWords.push_back(iInstr(opAddi, 5'd3, 5'd0, 16'hffff));
        progWords.push_back(rInstr(fnAdd, 5'd4, 5'd3, 5'd1));
        progWords.push_back(rInstr(fnSub, 5'd5, 5'd1, 5'd2));
        progWords.push_back(rInstr(fnSub, 5'd6, 5'd0, 5'd1));
        progWords.push_back(rInstr(fnAnd, 5'd7, 5'd2, 5'd1));
        progWords.push_back(rInstr(fnOr, 5'd8, 5'd1, 5'd2));
        progWords.push_back(rInstr(fnSlt, 5'd9, 5'd1, 5'd3));
        progWords.push_back(rInstr(fnSlt, 5'd10, 5'd3, 5'd1));
        progWords.push_back(rInstr(fnAdd, 5'd0, 5'd1, 5'd1));
        progWords.push_back(iInstr(opAddi, 5'd0, 5'd1, 16'd7));
        progWords.push_back(iInstr(opSlti, 5'd11, 5'd1, 16'hffff));
        progWords.push_back(iInstr(opSlti, 5'd12, 5'd3, 16'd4));
        progWords.push_back(iInstr(opAndi, 5'd13, 5'd3, 16'hfff0));
        progWords.push_back(iInstr(opOri, 5'd14, 5'd1, 16'h8000));
        progWords.push_back(iInstr(opAndi, 5'd15, 5'd3, 16'h7ff0));
        progWords.push_back(iInstr(opOri, 5'd16, 5'd0, 16'h1234));
        progWords.push_back(iInstr(opSw, 5'd14, 5'd0, 16'd8));
        progWords.push_back(iInstr(opLw, 5'd17, 5'd0, 16'd8));
        progWords.push_back(iInstr(opLw, 5'd18, 5'd0, 16'd12));
        progWords.push_back({6'h3f, 5'd1, 5'd2, 16'hffff});
        progWords.push_back(rInstr(fnAdd, 5'd19, 5'd1, 5'd2));
        progWords.push_back(rInstr(fnOr, 5'd20, 5'd2, 5'd17));
        runProgram();

        // 200 random instructions in four programs
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < 50; i++) begin
                progWords.push_back(randomInstr());
            end
            runProgram();
        end

        if (expected.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("%0d expected writebacks never arrived", expected.size());
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
